//--- common/ig_pkg.sv
package ig_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // greyscale pixel from the image memory
    localparam int PIX_W = 8;

    // one signed difference, enough for -255 .. 255
    localparam int DIFF_W = 10;

    // gradient word, gx in the upper half and gy in the lower half
    localparam int GRAD_W = 2 * DIFF_W;

    // both memories share one address width
    localparam int ADDR_W = 16;

    // coordinates reach 256 for the flush row after a 256-row image
    localparam int COORD_W = 9;

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic signed [DIFF_W-1:0] diff_t;
    typedef logic [COORD_W-1:0] coord_t;

    // ------------------------------------------------------------------------
    // pipeline beats
    // ------------------------------------------------------------------------

    // one pixel position on its way into the row buffer
    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
        pix_t   value;
        logic   flush;
    } pix_beat_t;

    // inputs for one output pixel
    typedef struct packed {
        logic valid;
        pix_t cur;
        pix_t right;
        pix_t below;
        logic last_col;
        logic last_row;
        logic last;
    } grad_win_t;

    // one finished gradient result
    typedef struct packed {
        logic  valid;
        diff_t gx;
        diff_t gy;
        logic  last;
    } grad_word_t;

endpackage

//--- rtl/img_scan.sv
module img_scan import ig_pkg::*; #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic               clk,
    input  logic               reset,
    output logic               img_rd,
    output logic [ADDR_W-1:0]  img_addr,
    output pix_beat_t          beat
);

    localparam int     NUM_PIX = IMG_W * IMG_H;
    localparam coord_t LAST_X  = coord_t'(IMG_W - 1);
    localparam coord_t LAST_Y  = coord_t'(IMG_H - 1);

    typedef enum logic [1:0] {
        S_INIT,
        S_SCAN,
        S_FLUSH,
        S_IDLE
    } state_t;

    state_t            state;
    coord_t            x_cnt;
    coord_t            y_cnt;
    logic [ADDR_W-1:0] addr_cnt;

    // ------------------------------------------------------------------------
    // request side: counters hold the coordinates of the current request
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_INIT;
            x_cnt    <= '0;
            y_cnt    <= '0;
            addr_cnt <= '0;
        end else begin
            case (state)
                S_INIT: state <= S_SCAN;
                S_SCAN: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    if (x_cnt == LAST_X) begin
                        x_cnt <= '0;
                        y_cnt <= y_cnt + 1'b1;
                        // y now points one past the image, the flush row
                        if (y_cnt == LAST_Y)
                            state <= S_FLUSH;
                    end else begin
                        x_cnt <= x_cnt + 1'b1;
                    end
                end
                S_FLUSH: begin
                    x_cnt <= x_cnt + 1'b1;
                    if (x_cnt == LAST_X)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign img_rd   = (state == S_SCAN);
    assign img_addr = addr_cnt;

    // delayed copy, lines up with img_di from the memory
    always_ff @(posedge clk) begin
        beat.x     <= x_cnt;
        beat.y     <= y_cnt;
        beat.value <= '0;
        beat.flush <= (state == S_FLUSH);
        if (reset)
            beat.valid <= 1'b0;
        else
            beat.valid <= (state == S_SCAN) || (state == S_FLUSH);
    end

    // no read past the last pixel address
    a_last_read: assert property (@(posedge clk) disable iff (reset)
        img_rd |-> (img_addr < NUM_PIX));

endmodule

//--- rtl/row_window.sv
module row_window import ig_pkg::*; #(
    parameter int IMG_W = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  pix_beat_t         beat,
    input  logic [PIX_W-1:0]  img_di,
    output grad_win_t         win
);

    localparam int     IDX_W  = $clog2(IMG_W);
    localparam coord_t LAST_X = coord_t'(IMG_W - 1);

    // previous row, one entry per column
    pix_t row_buf [IMG_W];

    logic [IDX_W-1:0] col;
    logic [IDX_W-1:0] col_next;
    logic             at_last_col;
    logic             buf_wr;
    pix_t             right_pix;
    pix_t             below_pix;

    assign col         = beat.x[IDX_W-1:0];
    assign col_next    = col + 1'b1;
    assign at_last_col = (beat.x == LAST_X);

    // the flush row carries no pixel data
    assign buf_wr = beat.valid && !beat.flush;

    // col_next may be out of range in the last column
    assign right_pix = at_last_col ? row_buf[col] : row_buf[col_next];
    assign below_pix = beat.flush ? pix_t'(0) : img_di;

    // ------------------------------------------------------------------------
    // row buffer
    // ------------------------------------------------------------------------

    // entry col is read for cur in the same cycle that it is replaced
    always_ff @(posedge clk) begin
        if (buf_wr)
            row_buf[col] <= img_di;
    end

    // ------------------------------------------------------------------------
    // window register
    // ------------------------------------------------------------------------

    // output pixel is (x, y-1), so the flush row marks the last image row
    always_ff @(posedge clk) begin
        win.cur      <= row_buf[col];
        win.right    <= right_pix;
        win.below    <= below_pix;
        win.last_col <= at_last_col;
        win.last_row <= beat.flush;
        win.last     <= beat.flush && at_last_col;
        if (reset)
            win.valid <= 1'b0;
        else
            win.valid <= beat.valid && (beat.y != '0);
    end

    // entry under a flush beat is left as it was
    a_flush_no_write: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.flush) |=> (row_buf[$past(col)] == $past(row_buf[col])));

endmodule

//--- rtl/grad_calc.sv
module grad_calc import ig_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  grad_win_t  win,
    output grad_word_t word
);

    localparam diff_t DIFF_MAX = diff_t'(255);
    localparam diff_t DIFF_MIN = -diff_t'(255);

    diff_t dx;
    diff_t dy;

    // ------------------------------------------------------------------------
    // forward differences
    // ------------------------------------------------------------------------

    // zero extend both operands, the ten bit result cannot overflow
    assign dx = diff_t'({2'b00, win.right}) - diff_t'({2'b00, win.cur});
    assign dy = diff_t'({2'b00, win.below}) - diff_t'({2'b00, win.cur});

    // ------------------------------------------------------------------------
    // result register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        // no right neighbour in the last column
        if (win.last_col)
            word.gx <= '0;
        else
            word.gx <= dx;

        // no lower neighbour in the last row
        if (win.last_row)
            word.gy <= '0;
        else
            word.gy <= dy;

        word.last <= win.last;

        if (reset)
            word.valid <= 1'b0;
        else
            word.valid <= win.valid;
    end

    // both components stay inside the range of two 8-bit pixels
    a_diff_range: assert property (@(posedge clk) disable iff (reset)
        word.valid |->
            (word.gx >= DIFF_MIN) && (word.gx <= DIFF_MAX) &&
            (word.gy >= DIFF_MIN) && (word.gy <= DIFF_MAX));

endmodule

//--- rtl/grad_store.sv
module grad_store import ig_pkg::*; #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  grad_word_t         word,
    output logic               grad_wr,
    output logic [ADDR_W-1:0]  grad_addr,
    output logic [GRAD_W-1:0]  grad_do,
    output logic               done
);

    localparam int NUM_PIX = IMG_W * IMG_H;

    // wraps to zero after a full 65536 pixel image
    logic [ADDR_W-1:0] addr_cnt;
    logic              last_wr;

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        grad_addr <= addr_cnt;
        grad_do   <= {word.gx, word.gy};
        last_wr   <= word.valid && word.last;
        if (reset)
            grad_wr <= 1'b0;
        else
            grad_wr <= word.valid;
    end

    // raster order, one address per word
    always_ff @(posedge clk) begin
        if (reset)
            addr_cnt <= '0;
        else if (word.valid)
            addr_cnt <= addr_cnt + 1'b1;
    end

    // ------------------------------------------------------------------------
    // completion
    // ------------------------------------------------------------------------

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else if (grad_wr && last_wr)
            done <= 1'b1;
    end

    a_quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !word.valid);

    // last flag from the window stage must meet the last address
    a_last_addr: assert property (@(posedge clk) disable iff (reset)
        (grad_wr && last_wr) |-> (grad_addr == ADDR_W'(NUM_PIX - 1)));

endmodule

//--- rtl/ig_top.sv
module ig_top import ig_pkg::*; #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic               clk,
    input  logic               reset,

    // image memory, read only
    output logic               img_rd,
    output logic [ADDR_W-1:0]  img_addr,
    input  logic [PIX_W-1:0]   img_di,

    // gradient memory, write only
    output logic               grad_wr,
    output logic [ADDR_W-1:0]  grad_addr,
    output logic [GRAD_W-1:0]  grad_do,

    output logic               done
);

    pix_beat_t  beat;
    grad_win_t  win;
    grad_word_t word;

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------

    img_scan #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) i_img_scan (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .beat     (beat)
    );

    // beat is already delayed to match the memory latency
    row_window #(
        .IMG_W (IMG_W)
    ) i_row_window (
        .clk    (clk),
        .reset  (reset),
        .beat   (beat),
        .img_di (img_di),
        .win    (win)
    );

    // ------------------------------------------------------------------------
    // arithmetic and write side
    // ------------------------------------------------------------------------

    grad_calc i_grad_calc (
        .clk   (clk),
        .reset (reset),
        .win   (win),
        .word  (word)
    );

    grad_store #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) i_grad_store (
        .clk       (clk),
        .reset     (reset),
        .word      (word),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

//--- verif/ig_tb_mem.sv
module img_mem_model import ig_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic               clk,
    input  logic               rd,
    input  logic [ADDR_W-1:0]  addr,
    output logic [PIX_W-1:0]   data
);

    // loaded by the testbench while the DUT sits in reset
    logic [PIX_W-1:0] mem [DEPTH];

    initial data = '0;

    // one cycle read latency
    always @(posedge clk) begin
        if (rd)
            data <= mem[addr];
    end

endmodule

module grad_capture_mem import ig_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic               clk,
    input  logic               clear,
    input  logic               wr,
    input  logic [ADDR_W-1:0]  addr,
    input  logic [GRAD_W-1:0]  data
);

    logic [GRAD_W-1:0] mem [DEPTH];

    // writes seen per address since the last clear
    int wr_count [DEPTH];

    always @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < DEPTH; i++)
                wr_count[i] <= 0;
        end else if (wr && addr < DEPTH) begin
            mem[addr]      <= data;
            wr_count[addr] <= wr_count[addr] + 1;
        end
    end

endmodule

//--- verif/ig_tb.sv
module ig_tb import ig_pkg::*; #(
    parameter int IMG_W = 16,
    parameter int IMG_H = 12
);

    localparam int NUM_PIX    = IMG_W * IMG_H;
    localparam int NUM_TESTS  = 5;
    // completion test starts a second run that reset cuts short
    localparam int NUM_RUNS   = NUM_TESTS + 1;
    localparam int RUN_CYCLES = IMG_W * (IMG_H + 1) + 20;
    localparam logic [31:0] SEED = 32'hd518_497a;

    localparam int PAT_RANDOM  = 0;
    localparam int PAT_RAMP    = 1;
    localparam int PAT_CHECKER = 2;
    localparam int PAT_ADDR    = 3;
    localparam int RAMP_DX     = 12;
    localparam int RAMP_DY     = 6;

    logic              clk;
    logic              reset;
    logic              img_rd;
    logic [ADDR_W-1:0] img_addr;
    logic [PIX_W-1:0]  img_di;
    logic              grad_wr;
    logic [ADDR_W-1:0] grad_addr;
    logic [GRAD_W-1:0] grad_do;
    logic              done;

    // reference copy of the picture in the image memory
    logic [PIX_W-1:0] image [NUM_PIX];

    int   err_count;
    int   tests_failed;
    int   exp_addr;
    int   exp_rd_addr;
    logic done_q;
    logic last_wr_q;

    ig_top #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    img_mem_model #(.DEPTH(NUM_PIX)) i_img_mem (
        .clk  (clk),
        .rd   (img_rd),
        .addr (img_addr),
        .data (img_di)
    );

    grad_capture_mem #(.DEPTH(NUM_PIX)) i_cap_mem (
        .clk   (clk),
        .clear (reset),
        .wr    (grad_wr),
        .addr  (grad_addr),
        .data  (grad_do)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // expected values
    // ------------------------------------------------------------------------

    // forward differences, zero where the neighbour lies outside the picture
    function automatic logic [GRAD_W-1:0] ref_word(input int addr);
        int x;
        int y;
        int gx;
        int gy;
        x = addr % IMG_W;
        y = addr / IMG_W;
        if (x == IMG_W - 1)
            gx = 0;
        else
            gx = int'(image[addr + 1]) - int'(image[addr]);
        if (y == IMG_H - 1)
            gy = 0;
        else
            gy = int'(image[addr + IMG_W]) - int'(image[addr]);
        return {gx[DIFF_W-1:0], gy[DIFF_W-1:0]};
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, name, got, expected);
            err_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        err_count++;
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic fill_image(input int pattern);
        int x;
        int y;
        for (int a = 0; a < NUM_PIX; a++) begin
            x = a % IMG_W;
            y = a / IMG_W;
            case (pattern)
                PAT_RAMP:    image[a] = PIX_W'(x * RAMP_DX + y * RAMP_DY);
                PAT_CHECKER: image[a] = ((x + y) % 2 == 0) ? 8'd0 : 8'd255;
                PAT_ADDR:    image[a] = PIX_W'((a * 37) ^ (a >> 8));
                default:     image[a] = PIX_W'($urandom());
            endcase
            i_img_mem.mem[a] = image[a];
        end
    endtask

    task automatic start_run(input int pattern);
        @(posedge clk);
        reset <= 1'b1;
        // scanner is idle from here on, safe to reload the memory
        repeat (2) @(posedge clk);
        fill_image(pattern);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic finish_run();
        while (done !== 1'b1)
            @(negedge clk);
        // done must hold with the write port quiet
        repeat (4) @(negedge clk);
    endtask

    task automatic check_coverage();
        for (int a = 0; a < NUM_PIX; a++)
            check_value($sformatf("write count of address %0d", a),
                        i_cap_mem.wr_count[a], 1);
    endtask

    // closed form results for the ramp and the checkerboard
    task automatic check_components(input int pattern);
        logic signed [DIFF_W-1:0] gx;
        logic signed [DIFF_W-1:0] gy;
        int x;
        int y;
        int step_x;
        int step_y;
        for (int a = 0; a < NUM_PIX; a++) begin
            x = a % IMG_W;
            y = a / IMG_W;
            gx = i_cap_mem.mem[a][GRAD_W-1:DIFF_W];
            gy = i_cap_mem.mem[a][DIFF_W-1:0];
            if (pattern == PAT_RAMP) begin
                step_x = RAMP_DX;
                step_y = RAMP_DY;
            end else begin
                // dark squares step up by full scale, light ones step down
                step_x = ((x + y) % 2 == 0) ? 255 : -255;
                step_y = step_x;
            end
            check_value("gx", gx, (x == IMG_W - 1) ? 0 : step_x);
            check_value("gy", gy, (y == IMG_H - 1) ? 0 : step_y);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (err_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, err_count - errors_before);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------------------
    // read and write monitor
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            exp_addr    = 0;
            exp_rd_addr = 0;
            done_q      = 1'b0;
            last_wr_q   = 1'b0;
        end else begin
            // reads run back to back from address 0 until the picture is fetched
            if (exp_rd_addr > 0 && exp_rd_addr < NUM_PIX)
                check_value("img_rd", img_rd, 1);
            if (img_rd) begin
                assert (exp_rd_addr < NUM_PIX)
                    else report_failure("image read past the last pixel");
                check_value("img_addr", img_addr, exp_rd_addr);
                exp_rd_addr++;
            end
            if (grad_wr) begin
                assert (!done) else report_failure("gradient write after done");
                check_value("grad_addr", grad_addr, exp_addr);
                if (grad_addr < NUM_PIX)
                    check_value("grad_do", grad_do, ref_word(grad_addr));
                exp_addr++;
            end
            if (done && !done_q)
                assert (last_wr_q) else report_failure("done rose without a final write");
            if (done_q)
                assert (done) else report_failure("done fell without a reset");
            done_q    = done;
            last_wr_q = grad_wr && (grad_addr == NUM_PIX - 1);
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        int errors_before;
        void'($urandom(SEED));
        clk          = 1'b0;
        reset        = 1'b1;
        err_count    = 0;
        tests_failed = 0;

        errors_before = err_count;
        start_run(PAT_RANDOM);
        finish_run();
        report_test("random image", errors_before);

        errors_before = err_count;
        start_run(PAT_RAMP);
        finish_run();
        check_components(PAT_RAMP);
        report_test("ramp edges", errors_before);

        errors_before = err_count;
        start_run(PAT_CHECKER);
        finish_run();
        check_components(PAT_CHECKER);
        report_test("checkerboard extremes", errors_before);

        errors_before = err_count;
        start_run(PAT_ADDR);
        finish_run();
        check_coverage();
        report_test("address coverage", errors_before);

        // done is still up from the previous run
        errors_before = err_count;
        check_value("done", done, 1);
        start_run(PAT_RANDOM);
        check_value("done", done, 0);
        while (exp_addr < NUM_PIX / 4)
            @(negedge clk);
        check_value("done", done, 0);
        start_run(PAT_RANDOM);
        check_value("done", done, 0);
        finish_run();
        check_coverage();
        report_test("completion and mid-run reset", errors_before);

        $display("%0d of %0d tests passed, %0d errors in total",
                 NUM_TESTS - tests_failed, NUM_TESTS, err_count);
        if (err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // upper bound on the whole sequence
    initial begin
        repeat (NUM_RUNS * RUN_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the DUT did not finish",
                 NUM_RUNS * RUN_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb.f
common/ig_pkg.sv
rtl/img_scan.sv
rtl/row_window.sv
rtl/grad_calc.sv
rtl/grad_store.sv
rtl/ig_top.sv
verif/ig_tb_mem.sv
verif/ig_tb.sv
